// File: logic/tsn_tg_pkg.sv
`default_nettype none

package tsn_tg_pkg;

    // ******************************
    // queue and list sizes
    // ******************************
    localparam int NUM_QUEUES     = 8;
    localparam int QID_W          = $clog2(NUM_QUEUES);
    localparam int SLOTS_PER_WORD = 16;
    localparam int SLOT_IDX_W     = $clog2(SLOTS_PER_WORD);
    localparam int GCL_DEPTH      = 32;
    localparam int GCL_ADDR_W     = 5;
    localparam int GCL_W          = SLOTS_PER_WORD * NUM_QUEUES;

    // ******************************
    // slot timing
    // ******************************
    localparam int SLOT_W   = 10;
    localparam int PERIOD_W = 11;
    // period counted in sixteen-slot groups
    localparam int GROUP_W  = PERIOD_W - SLOT_IDX_W;

    localparam int SLOT_CYCLES = 8;
    localparam int PHASE_W     = $clog2(SLOT_CYCLES);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(SLOT_CYCLES - 1);

    // pending-packet counter, saturating
    localparam int CNT_W = 4;
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    // list read sequence in gate_ctrl
    localparam logic [1:0] GC_IDLE  = 2'd0;
    localparam logic [1:0] GC_WAIT1 = 2'd1;
    localparam logic [1:0] GC_WAIT2 = 2'd2;
    localparam logic [1:0] GC_ADV   = 2'd3;

    // one list word, written flat, read as one gate byte per slot
    typedef union packed {
        logic [GCL_W-1:0] flat;
        logic [SLOTS_PER_WORD-1:0][NUM_QUEUES-1:0] gate;
    } gcl_word_u;

endpackage

`default_nettype wire

// File: logic/slot_timer.sv
`timescale 1ns/1ps
`default_nettype none

module slot_timer (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              test_start,
    input  wire logic [tsn_tg_pkg::PERIOD_W-1:0]   period_slots,
    output logic      [tsn_tg_pkg::SLOT_W-1:0]     time_slot,
    output logic                                   slot_switch
);

    logic [tsn_tg_pkg::PHASE_W-1:0]  phase;
    logic [tsn_tg_pkg::PERIOD_W-1:0] slot_inc;
    logic                            slot_end;
    logic                            period_end;

    // ******************************
    // phase and slot counters
    // ******************************
    assign slot_end   = (phase == tsn_tg_pkg::PHASE_LAST);
    // next slot number, one bit wider to compare against the period
    assign slot_inc   = {1'b0, time_slot} + 1'b1;
    assign period_end = (slot_inc >= period_slots);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= '0;
            time_slot <= '0;
        end else if (!test_start) begin
            // held at slot 0 phase 0 so the run starts at once
            phase     <= '0;
            time_slot <= '0;
        end else if (slot_end) begin
            phase     <= '0;
            time_slot <= period_end ? '0 : slot_inc[tsn_tg_pkg::SLOT_W-1:0];
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // first cycle of each slot
    assign slot_switch = test_start && (phase == '0);

    // slot number stays inside the configured period
    a_slot_in_period: assert property (@(posedge clk) disable iff (!rst_n)
        test_start |-> ({1'b0, time_slot} < period_slots));

endmodule

`default_nettype wire

// File: logic/gcl_ram.sv
`timescale 1ns/1ps
`default_nettype none

module gcl_ram (
    input  wire logic                                clk,
    input  wire logic                                cfg_wr,
    input  wire logic [tsn_tg_pkg::GCL_ADDR_W-1:0]   cfg_addr,
    input  wire logic [tsn_tg_pkg::GCL_W-1:0]        cfg_data,
    input  wire logic                                gcl_rd,
    input  wire logic [tsn_tg_pkg::GCL_ADDR_W-1:0]   gcl_addr,
    output tsn_tg_pkg::gcl_word_u                    gcl_data
);

    // list storage, one word per sixteen slots
    tsn_tg_pkg::gcl_word_u mem [tsn_tg_pkg::GCL_DEPTH];

    // ******************************
    // configuration write
    // ******************************
    // host side, flat view of the word
    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            mem[cfg_addr].flat <= cfg_data;
        end
    end

    // ******************************
    // registered read
    // ******************************
    // data one cycle after the strobe
    // kept until the next strobe so gate_ctrl can index it all group long
    always_ff @(posedge clk) begin
        if (gcl_rd) begin
            gcl_data <= mem[gcl_addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/gate_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gate_ctrl (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                test_start,
    input  wire logic [tsn_tg_pkg::SLOT_W-1:0]       time_slot,
    input  wire logic                                slot_switch,
    input  wire logic [tsn_tg_pkg::PERIOD_W-1:0]     period_slots,
    input  wire logic [tsn_tg_pkg::NUM_QUEUES-1:0]   req,
    input  wire tsn_tg_pkg::gcl_word_u               gcl_data,
    output logic                                     gcl_rd,
    output logic      [tsn_tg_pkg::GCL_ADDR_W-1:0]   gcl_addr,
    output logic      [tsn_tg_pkg::NUM_QUEUES-1:0]   gate_valid
);

    logic [1:0]                      state;
    logic [tsn_tg_pkg::GROUP_W-1:0]  addr_inc;
    logic                            addr_wrap;
    logic                            group_start;

    // slot switch into a slot whose low four bits are zero
    assign group_start = slot_switch &&
                         (time_slot[tsn_tg_pkg::SLOT_IDX_W-1:0] == '0);

    // address widened to the group count of the period
    assign addr_inc  = {{(tsn_tg_pkg::GROUP_W - tsn_tg_pkg::GCL_ADDR_W){1'b0}}, gcl_addr}
                       + 1'b1;
    assign addr_wrap = (addr_inc >= period_slots[tsn_tg_pkg::PERIOD_W-1:tsn_tg_pkg::SLOT_IDX_W]);

    // ******************************
    // list read sequence
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= tsn_tg_pkg::GC_IDLE;
            gcl_rd   <= 1'b0;
            gcl_addr <= '0;
        end else if (!test_start) begin
            // idle run restarts from word 0
            state    <= tsn_tg_pkg::GC_IDLE;
            gcl_rd   <= 1'b0;
            gcl_addr <= '0;
        end else begin
            case (state)
                tsn_tg_pkg::GC_IDLE: begin
                    // read strobe lands one cycle after the switch
                    gcl_rd <= group_start;
                    if (group_start) begin
                        state <= tsn_tg_pkg::GC_WAIT1;
                    end
                end
                tsn_tg_pkg::GC_WAIT1: begin
                    gcl_rd <= 1'b0;
                    state  <= tsn_tg_pkg::GC_WAIT2;
                end
                tsn_tg_pkg::GC_WAIT2: begin
                    state <= tsn_tg_pkg::GC_ADV;
                end
                tsn_tg_pkg::GC_ADV: begin
                    // last group of the period wraps back to word 0
                    gcl_addr <= addr_wrap ? '0 : addr_inc[tsn_tg_pkg::GCL_ADDR_W-1:0];
                    state    <= tsn_tg_pkg::GC_IDLE;
                end
                default: begin
                    gcl_rd <= 1'b0;
                    state  <= tsn_tg_pkg::GC_IDLE;
                end
            endcase
        end
    end

    // ******************************
    // per-slot gating
    // ******************************
    // gate byte of the current slot masks the pending requests
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gate_valid <= '0;
        end else if (!test_start) begin
            gate_valid <= '0;
        end else begin
            gate_valid <= gcl_data.gate[time_slot[tsn_tg_pkg::SLOT_IDX_W-1:0]] & req;
        end
    end

    // read sequence back in idle by every group start
    a_rd_at_group: assert property (@(posedge clk) disable iff (!rst_n)
        group_start |=> gcl_rd);

endmodule

`default_nettype wire

// File: logic/queue_req.sv
`timescale 1ns/1ps
`default_nettype none

module queue_req (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic [tsn_tg_pkg::NUM_QUEUES-1:0]   enq,
    input  wire logic                                grant,
    input  wire logic [tsn_tg_pkg::QID_W-1:0]        grant_queue,
    output logic      [tsn_tg_pkg::NUM_QUEUES-1:0]   req
);

    logic [tsn_tg_pkg::NUM_QUEUES-1:0][tsn_tg_pkg::CNT_W-1:0] cnt;
    logic [tsn_tg_pkg::NUM_QUEUES-1:0]                        grant_oh;
    logic [tsn_tg_pkg::NUM_QUEUES-1:0]                        full;

    // granted queue as one bit per queue, zero without a grant
    assign grant_oh = {{(tsn_tg_pkg::NUM_QUEUES - 1){1'b0}}, grant} << grant_queue;

    always_comb begin
        for (int q = 0; q < tsn_tg_pkg::NUM_QUEUES; q++) begin
            full[q] = (cnt[q] == tsn_tg_pkg::CNT_MAX);
        end
    end

    // ******************************
    // pending-packet counters
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            req <= '0;
        end else begin
            for (int q = 0; q < tsn_tg_pkg::NUM_QUEUES; q++) begin
                // enqueue and grant together cancel out
                if (enq[q] && !grant_oh[q] && !full[q]) begin
                    cnt[q] <= cnt[q] + 1'b1;
                end else if (grant_oh[q] && !enq[q] && (cnt[q] != '0)) begin
                    cnt[q] <= cnt[q] - 1'b1;
                end
                // request trails the counter by one cycle
                req[q] <= (cnt[q] != '0);
            end
        end
    end

    // tx_select only grants queues that still hold packets
    a_grant_pending: assert property (@(posedge clk) disable iff (!rst_n)
        grant |-> (cnt[grant_queue] != '0));

    // no enqueue is lost to a saturated counter
    a_enq_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        (enq & ~grant_oh & full) == '0);

endmodule

`default_nettype wire

// File: logic/tx_select.sv
`timescale 1ns/1ps
`default_nettype none

module tx_select (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                slot_switch,
    input  wire logic [tsn_tg_pkg::SLOT_W-1:0]       time_slot,
    input  wire logic [tsn_tg_pkg::NUM_QUEUES-1:0]   gate_valid,
    output logic                                     grant,
    output logic      [tsn_tg_pkg::QID_W-1:0]        grant_queue,
    output logic      [tsn_tg_pkg::SLOT_W-1:0]       grant_slot
);

    logic [tsn_tg_pkg::PHASE_W-1:0] phase;
    logic [tsn_tg_pkg::PHASE_W-1:0] cur_phase;
    logic [tsn_tg_pkg::QID_W-1:0]   pick;
    logic                           sample;

    // ******************************
    // local slot phase
    // ******************************
    // switch cycle counts as phase 0 whatever the register holds
    assign cur_phase = slot_switch ? '0 : phase;
    assign sample    = (cur_phase == tsn_tg_pkg::PHASE_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else begin
            phase <= cur_phase + 1'b1;
        end
    end

    // lowest-indexed valid queue wins
    always_comb begin
        pick = '0;
        for (int q = tsn_tg_pkg::NUM_QUEUES - 1; q >= 0; q--) begin
            if (gate_valid[q]) begin
                pick = q[tsn_tg_pkg::QID_W-1:0];
            end
        end
    end

    // ******************************
    // grant register
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= 1'b0;
        end else begin
            grant <= sample && (gate_valid != '0);
        end
    end

    // queue and slot ride along with the pulse into the next slot
    always_ff @(posedge clk) begin
        if (sample) begin
            grant_queue <= pick;
            grant_slot  <= time_slot;
        end
    end

endmodule

`default_nettype wire

// File: logic/tsn_tg_top.sv
`timescale 1ns/1ps
`default_nettype none

module tsn_tg_top (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                test_start,
    input  wire logic [tsn_tg_pkg::PERIOD_W-1:0]     period_slots,
    input  wire logic                                cfg_wr,
    input  wire logic [tsn_tg_pkg::GCL_ADDR_W-1:0]   cfg_addr,
    input  wire logic [tsn_tg_pkg::GCL_W-1:0]        cfg_data,
    input  wire logic [tsn_tg_pkg::NUM_QUEUES-1:0]   enq,
    output logic                                     grant,
    output logic      [tsn_tg_pkg::QID_W-1:0]        grant_queue,
    output logic      [tsn_tg_pkg::SLOT_W-1:0]       grant_slot,
    output logic      [tsn_tg_pkg::SLOT_W-1:0]       time_slot
);

    logic                                slot_switch;
    logic                                gcl_rd;
    logic [tsn_tg_pkg::GCL_ADDR_W-1:0]   gcl_addr;
    tsn_tg_pkg::gcl_word_u               gcl_data;
    logic [tsn_tg_pkg::NUM_QUEUES-1:0]   req;
    logic [tsn_tg_pkg::NUM_QUEUES-1:0]   gate_valid;

    // ******************************
    // slot timing and list
    // ******************************
    slot_timer u_slot_timer (
        .clk(clk), .rst_n(rst_n), .test_start(test_start),
        .period_slots(period_slots), .time_slot(time_slot), .slot_switch(slot_switch)
    );

    gcl_ram u_gcl_ram (
        .clk(clk), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .gcl_rd(gcl_rd), .gcl_addr(gcl_addr), .gcl_data(gcl_data)
    );

    gate_ctrl u_gate_ctrl (
        .clk(clk), .rst_n(rst_n), .test_start(test_start), .time_slot(time_slot),
        .slot_switch(slot_switch), .period_slots(period_slots), .req(req),
        .gcl_data(gcl_data), .gcl_rd(gcl_rd), .gcl_addr(gcl_addr),
        .gate_valid(gate_valid)
    );

    // ******************************
    // queues and selection
    // ******************************
    // grant loops back to drain the queue counters
    queue_req u_queue_req (
        .clk(clk), .rst_n(rst_n), .enq(enq), .grant(grant),
        .grant_queue(grant_queue), .req(req)
    );

    tx_select u_tx_select (
        .clk(clk), .rst_n(rst_n), .slot_switch(slot_switch), .time_slot(time_slot),
        .gate_valid(gate_valid), .grant(grant), .grant_queue(grant_queue),
        .grant_slot(grant_slot)
    );

endmodule

`default_nettype wire

// File: sim/tb_tsn_tg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tsn_tg;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int RUN_PERIODS  = 3;
    localparam int PERIOD_A     = 32;
    localparam int PERIOD_B     = 48;
    localparam int IDLE_CYCLES  = 2 * tsn_tg_pkg::SLOT_CYCLES;
    // both runs, two list loads, idle gaps and reset
    localparam int TEST_CYCLES  = RUN_PERIODS * (PERIOD_A + PERIOD_B) * tsn_tg_pkg::SLOT_CYCLES
                                  + 2 * (tsn_tg_pkg::GCL_DEPTH + IDLE_CYCLES) + RESET_CYCLES;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 200;

    logic                                clk;
    logic                                rst_n;
    logic                                test_start;
    logic [tsn_tg_pkg::PERIOD_W-1:0]     period_slots;
    logic                                cfg_wr;
    logic [tsn_tg_pkg::GCL_ADDR_W-1:0]   cfg_addr;
    logic [tsn_tg_pkg::GCL_W-1:0]        cfg_data;
    logic [tsn_tg_pkg::NUM_QUEUES-1:0]   enq;
    logic                                grant;
    logic [tsn_tg_pkg::QID_W-1:0]        grant_queue;
    logic [tsn_tg_pkg::SLOT_W-1:0]       grant_slot;
    logic [tsn_tg_pkg::SLOT_W-1:0]       time_slot;

    // ******************************
    // reference model state
    // ******************************
    logic [tsn_tg_pkg::GCL_W-1:0] list_mem [tsn_tg_pkg::GCL_DEPTH];
    int pend [tsn_tg_pkg::NUM_QUEUES];
    // slot and phase the DUT should be in
    int m_slot;
    int m_phase;
    int m_period;
    int cycle_cnt;

    tsn_tg_top u_dut (
        .clk(clk), .rst_n(rst_n), .test_start(test_start), .period_slots(period_slots),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data), .enq(enq),
        .grant(grant), .grant_queue(grant_queue), .grant_slot(grant_slot),
        .time_slot(time_slot)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hang guard
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $fatal(1);
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // gate byte of a slot, bit q opens queue q
    function automatic logic [tsn_tg_pkg::NUM_QUEUES-1:0] gate_byte(input int slot);
        logic [tsn_tg_pkg::GCL_W-1:0] word;
        word = list_mem[tsn_tg_pkg::GCL_ADDR_W'(slot / tsn_tg_pkg::SLOTS_PER_WORD)];
        gate_byte = word[(slot % tsn_tg_pkg::SLOTS_PER_WORD) * tsn_tg_pkg::NUM_QUEUES
                         +: tsn_tg_pkg::NUM_QUEUES];
    endfunction

    function automatic logic [tsn_tg_pkg::NUM_QUEUES-1:0] pending_mask();
        pending_mask = '0;
        for (int q = 0; q < tsn_tg_pkg::NUM_QUEUES; q++) begin
            pending_mask[q] = (pend[q] != 0);
        end
    endfunction

    // -1 for an empty mask
    function automatic int lowest_set(input logic [tsn_tg_pkg::NUM_QUEUES-1:0] m);
        lowest_set = -1;
        for (int q = 0; q < tsn_tg_pkg::NUM_QUEUES; q++) begin
            if (m[q] && lowest_set < 0) begin
                lowest_set = q;
            end
        end
    endfunction

    // ******************************
    // stimulus
    // ******************************
    task automatic write_list();
        logic [tsn_tg_pkg::GCL_W-1:0] word;
        for (int a = 0; a < tsn_tg_pkg::GCL_DEPTH; a++) begin
            for (int w = 0; w < tsn_tg_pkg::GCL_W / 32; w++) begin
                word[w * 32 +: 32] = $urandom;
            end
            list_mem[a] = word;
            cfg_wr   = 1'b1;
            cfg_addr = tsn_tg_pkg::GCL_ADDR_W'(a);
            cfg_data = word;
            next_cycle();
        end
        cfg_wr = 1'b0;
    endtask

    // sparse enqueues in phases 0 to 3, none into a full queue
    task automatic drive_enq();
        logic [tsn_tg_pkg::NUM_QUEUES-1:0] e;
        int r;
        e = '0;
        for (int q = 0; q < tsn_tg_pkg::NUM_QUEUES; q++) begin
            r = $urandom_range(0, 31);
            if (m_phase < 4 && r == 0 && pend[q] < int'(tsn_tg_pkg::CNT_MAX)) begin
                e[q] = 1'b1;
                pend[q]++;
            end
        end
        enq = e;
    endtask

    // ******************************
    // per-cycle checks
    // ******************************
    task automatic check_cycle();
        logic [tsn_tg_pkg::NUM_QUEUES-1:0] gates;
        logic [tsn_tg_pkg::NUM_QUEUES-1:0] open_pend;
        int prev;
        int exp_q;
        assert (time_slot == tsn_tg_pkg::SLOT_W'(m_slot)) else
            stop_on_error($sformatf("Error: time_slot got %h expected %h", time_slot, m_slot));
        if (m_phase != 0) begin
            assert (grant == 1'b0) else
                stop_on_error($sformatf("Error: grant got %h expected %h at phase %0d",
                                        grant, 1'b0, m_phase));
        end else begin
            // grant for the slot that just ended
            prev      = (m_slot == 0) ? m_period - 1 : m_slot - 1;
            gates     = gate_byte(prev);
            open_pend = gates & pending_mask();
            exp_q     = lowest_set(open_pend);
            if (exp_q < 0) begin
                assert (grant == 1'b0) else
                    stop_on_error($sformatf("Error: grant got %h expected %h for slot %h",
                                            grant, 1'b0, prev));
            end else begin
                assert (grant == 1'b1) else
                    stop_on_error($sformatf("Error: grant got %h expected %h for slot %h",
                                            grant, 1'b1, prev));
                assert (grant_slot == tsn_tg_pkg::SLOT_W'(prev)) else
                    stop_on_error($sformatf("Error: grant_slot got %h expected %h",
                                            grant_slot, prev));
                assert (gates[grant_queue] && pend[grant_queue] != 0) else
                    stop_on_error($sformatf("Granted queue %0d is closed or empty in slot %0d",
                                            grant_queue, prev));
                assert (grant_queue == tsn_tg_pkg::QID_W'(exp_q)) else
                    stop_on_error($sformatf("Error: grant_queue got %h expected %h",
                                            grant_queue, exp_q));
                pend[exp_q]--;
            end
        end
    endtask

    // three periods, then test_start drops on the wrap cycle
    task automatic run_test(input int period);
        int total;
        total        = RUN_PERIODS * period * tsn_tg_pkg::SLOT_CYCLES;
        m_period     = period;
        m_slot       = 0;
        m_phase      = 0;
        period_slots = tsn_tg_pkg::PERIOD_W'(period);
        test_start   = 1'b1;
        drive_enq();
        for (int n = 0; n < total; n++) begin
            next_cycle();
            m_phase++;
            if (m_phase == tsn_tg_pkg::SLOT_CYCLES) begin
                m_phase = 0;
                m_slot  = (m_slot + 1 == m_period) ? 0 : m_slot + 1;
            end
            check_cycle();
            if (n == total - 1) begin
                test_start = 1'b0;
                enq        = '0;
            end else begin
                drive_enq();
            end
        end
        // stopped generator stays quiet
        repeat (IDLE_CYCLES) begin
            next_cycle();
            assert (grant == 1'b0) else
                stop_on_error($sformatf("Error: grant got %h expected %h while stopped",
                                        grant, 1'b0));
            assert (time_slot == '0) else
                stop_on_error($sformatf("Error: time_slot got %h expected %h while stopped",
                                        time_slot, 0));
        end
    endtask

    initial begin
        void'($urandom(32'h1c65));
        rst_n        = 1'b0;
        test_start   = 1'b0;
        period_slots = tsn_tg_pkg::PERIOD_W'(PERIOD_A);
        cfg_wr       = 1'b0;
        cfg_addr     = '0;
        cfg_data     = '0;
        enq          = '0;
        m_slot       = 0;
        m_phase      = 0;
        m_period     = PERIOD_A;
        for (int q = 0; q < tsn_tg_pkg::NUM_QUEUES; q++) begin
            pend[q] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        write_list();
        run_test(PERIOD_A);
        // fresh list, longer period reaches word 2
        write_list();
        run_test(PERIOD_B);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
logic/tsn_tg_pkg.sv
logic/slot_timer.sv
logic/gcl_ram.sv
logic/gate_ctrl.sv
logic/queue_req.sv
logic/tx_select.sv
logic/tsn_tg_top.sv
sim/tb_tsn_tg.sv

// File: run_sim.sh
#!/bin/sh
# build and run the gating stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_tsn_tg -f tb.f -o tb_tsn_tg
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_tsn_tg > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# the log decides the verdict, a crash counts as failure too
if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
